// ==== rtl/ps2_frame_pkg.sv ====
package ps2_frame_pkg;

  ////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////

  // bit 0 start, bits 8..1 data lsb first, bit 9 parity, bit 10 stop
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;   // start + data + parity + stop
  localparam int TX_SHIFTS  = 10;   // start bit already sent by the request to send
  localparam int BIT_CNT_W  = 4;    // holds 0..FRAME_BITS

  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT  = 1'b1;

  ////////////////////////////////////////
  // parity
  ////////////////////////////////////////

  // ones in data plus returned bit always odd
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
    return ~(^data);                // even count of ones -> parity 1
  endfunction

endpackage

// ==== rtl/ps2_ctrl_pkg.sv ====
package ps2_ctrl_pkg;

  ////////////////////////////////////////
  // clock and delays
  ////////////////////////////////////////

  localparam int SYS_CLK_HZ = 10_000_000;

  localparam int CLK_HOLD_CYCLES     = SYS_CLK_HZ / 10_000;  // 100 us clock held low
  localparam int DATA_SETUP_CYCLES   = SYS_CLK_HZ / 50_000;  // 20 us with both lines low
  localparam int RELEASE_WAIT_CYCLES = 63;   // let the clock line float back up
  localparam int DEBOUNCE_CYCLES     = 15;   // stable cycles before a level is taken
  localparam int TIMER_W             = 10;   // covers CLK_HOLD_CYCLES

  ////////////////////////////////////////
  // link states
  ////////////////////////////////////////

  // rx_* receive from device, tx_* request to send and transmit
  typedef enum logic [3:0] {
    IDLE,
    RX_NEG_EDGE,                    // sample a bit
    RX_CLK_LOW,
    RX_CLK_HIGH,
    TX_FORCE_CLK_LOW,               // hold clock low 100 us
    TX_BRING_DATA_LOW,              // start bit with clock still low
    TX_RELEASE_CLK,
    TX_WAIT_FIRST_NEG_EDGE,
    TX_CLK_LOW,                     // shift next bit onto data
    TX_WAIT_POS_EDGE,
    TX_CLK_HIGH,
    TX_WAIT_POS_EDGE_BEFORE_ACK,
    TX_WAIT_ACK,
    TX_RECEIVED_ACK,
    TX_ERROR_NO_ACK
  } link_state_t;

endpackage

// ==== rtl/ps2_line_filter.sv ====
`timescale 1ns/1ps

module ps2_line_filter (
  input  logic clk,
  input  logic rst,
  input  logic line_in,             // raw open-collector level, async to clk
  output logic line_s               // debounced, clk domain
);

  import ps2_ctrl_pkg::*;

  logic                                 last_seen;   // level sampled last cycle
  logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] stable_cnt;  // cycles last_seen has held

  // a new level restarts the count, a full count promotes it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_seen  <= 1'b1;           // idle bus is high
      stable_cnt <= '0;
      line_s     <= 1'b1;
    end else if (line_in != last_seen) begin
      last_seen  <= line_in;        // change seen, start over
      stable_cnt <= '0;
    end else if (int'(stable_cnt) == DEBOUNCE_CYCLES) begin
      line_s     <= last_seen;      // held long enough
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

// ==== rtl/ps2_delay_timer.sv ====
`timescale 1ns/1ps

module ps2_delay_timer (
  input  logic clk,
  input  logic rst,
  input  logic timer_clear,         // back to zero
  input  logic timer_run,           // count up one per cycle
  output logic hold_done,
  output logic setup_done,
  output logic release_done
);

  import ps2_ctrl_pkg::*;

  logic [TIMER_W-1:0] count;

  // clear wins over run, count sticks at all ones
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (timer_clear) begin
      count <= '0;
    end else if (timer_run && count != '1) begin
      count <= count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // delay compares
  ////////////////////////////////////////

  assign hold_done    = (count == TIMER_W'(CLK_HOLD_CYCLES));      // clock low long enough
  assign setup_done   = (count == TIMER_W'(DATA_SETUP_CYCLES));    // data low long enough
  assign release_done = (count == TIMER_W'(RELEASE_WAIT_CYCLES));  // clock had time to rise

endmodule

// ==== rtl/ps2_frame_shifter.sv ====
`timescale 1ns/1ps

module ps2_frame_shifter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [ps2_frame_pkg::DATA_BITS-1:0] tx_data,
  input  logic                                frame_load,   // build tx frame
  input  logic                                frame_shift,  // one bit in and out
  input  logic                                count_clear,
  input  logic                                rx_capture,   // take received byte
  input  logic                                data_s,       // filtered data line
  output logic                                tx_bit,
  output logic                                frame_full,
  output logic                                tx_last,
  output logic                                parity_ok,
  output logic [ps2_frame_pkg::DATA_BITS-1:0] rx_data
);

  import ps2_frame_pkg::*;

  logic [FRAME_BITS-1:0] frame;     // bit 0 is the next bit out, and the first bit in at the end
  logic [BIT_CNT_W-1:0]  bit_cnt;   // bits moved so far

  ////////////////////////////////////////
  // frame register
  ////////////////////////////////////////

  // receive fills from the top so the start bit lands in bit 0
  // transmit empties from bit 0, top fill is don't care
  always_ff @(posedge clk) begin
    if (frame_load) begin
      frame <= {STOP_BIT, odd_parity(tx_data), tx_data, START_BIT};
    end else if (frame_shift) begin
      frame <= {data_s, frame[FRAME_BITS-1:1]};
    end
  end

  ////////////////////////////////////////
  // bit counter
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (count_clear) begin
      bit_cnt <= '0;
    end else if (frame_shift) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign frame_full = (bit_cnt == BIT_CNT_W'(FRAME_BITS));  // whole rx frame in
  assign tx_last    = (bit_cnt == BIT_CNT_W'(TX_SHIFTS));   // stop bit now on bit 0

  ////////////////////////////////////////
  // received byte
  ////////////////////////////////////////

  // parity bit sits just above the data bits
  assign parity_ok = (frame[DATA_BITS+1] == odd_parity(frame[DATA_BITS:1]));
  assign tx_bit    = frame[0];

  // holds until the next good frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_data <= '0;
    end else if (rx_capture) begin
      rx_data <= frame[DATA_BITS:1];
    end
  end

endmodule

// ==== rtl/ps2_link_fsm.sv ====
`timescale 1ns/1ps

module ps2_link_fsm (
  input  logic clk,
  input  logic rst,
  input  logic tx_valid,            // client byte ready, only seen in IDLE
  input  logic clk_s,               // filtered device clock
  input  logic data_s,              // filtered data line
  input  logic hold_done,
  input  logic setup_done,
  input  logic release_done,
  input  logic tx_bit,
  input  logic frame_full,
  input  logic tx_last,
  input  logic parity_ok,
  output logic timer_clear,
  output logic timer_run,
  output logic frame_load,
  output logic frame_shift,
  output logic count_clear,
  output logic rx_capture,
  output logic ps2_clk_low,         // 1 pulls the clock line low
  output logic ps2_data_low,        // 1 pulls the data line low
  output logic rx_valid,
  output logic busy,
  output logic err
);

  import ps2_ctrl_pkg::*;
  import ps2_frame_pkg::*;

  link_state_t state, state_next;
  logic        clk_low_next;
  logic        data_low_next;
  logic        rx_valid_next;
  logic        err_next;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= IDLE;
      ps2_clk_low  <= 1'b0;         // both lines released
      ps2_data_low <= 1'b0;
      rx_valid     <= 1'b0;
      err          <= 1'b0;
    end else begin
      state        <= state_next;
      ps2_clk_low  <= clk_low_next;
      ps2_data_low <= data_low_next;
      rx_valid     <= rx_valid_next;
      err          <= err_next;
    end
  end

  assign busy = (state != IDLE);

  ////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////

  always_comb begin
    state_next    = state;
    clk_low_next  = 1'b0;           // lines float unless a state drives them
    data_low_next = 1'b0;
    rx_valid_next = 1'b0;
    err_next      = 1'b0;
    timer_clear   = 1'b1;           // timer parked at zero by default
    timer_run     = 1'b0;
    frame_load    = 1'b0;
    frame_shift   = 1'b0;
    count_clear   = 1'b0;
    rx_capture    = 1'b0;

    case (state)
      IDLE: begin
        count_clear = 1'b1;
        if (tx_valid) begin         // client beats a device start
          frame_load = 1'b1;
          state_next = TX_FORCE_CLK_LOW;
        end else if (!clk_s) begin  // device pulled the clock low
          state_next = RX_NEG_EDGE;
        end
      end

      // receive
      RX_NEG_EDGE: begin
        frame_shift = 1'b1;         // data is valid on the falling edge
        state_next  = RX_CLK_LOW;
      end
      RX_CLK_LOW: begin
        if (clk_s) state_next = RX_CLK_HIGH;
      end
      RX_CLK_HIGH: begin
        if (frame_full) begin
          state_next = IDLE;
          if (parity_ok) begin
            rx_capture    = 1'b1;
            rx_valid_next = 1'b1;
          end else begin
            err_next = 1'b1;        // byte dropped, rx_data kept
          end
        end else if (!clk_s) begin
          state_next = RX_NEG_EDGE;
        end
      end

      // request to send
      TX_FORCE_CLK_LOW: begin
        clk_low_next = 1'b1;
        if (hold_done) state_next = TX_BRING_DATA_LOW;
        else begin
          timer_clear = 1'b0;
          timer_run   = 1'b1;
        end
      end
      TX_BRING_DATA_LOW: begin
        clk_low_next  = 1'b1;
        data_low_next = !START_BIT; // device reads this as the start bit
        if (setup_done) state_next = TX_RELEASE_CLK;
        else begin
          timer_clear = 1'b0;
          timer_run   = 1'b1;
        end
      end
      TX_RELEASE_CLK: begin
        data_low_next = !START_BIT;
        state_next    = TX_WAIT_FIRST_NEG_EDGE;
      end
      TX_WAIT_FIRST_NEG_EDGE: begin
        data_low_next = !START_BIT;
        timer_clear   = 1'b0;
        if (!release_done) timer_run = 1'b1;  // filter lag on the rising clock
        else if (!clk_s) state_next = TX_CLK_LOW;
      end

      // bit transmit
      TX_CLK_LOW: begin
        data_low_next = !tx_bit;
        frame_shift   = 1'b1;       // next bit onto bit 0
        state_next    = TX_WAIT_POS_EDGE;
      end
      TX_WAIT_POS_EDGE: begin
        data_low_next = !tx_bit;
        if (tx_last) begin
          data_low_next = 1'b0;     // released line is the stop bit
          state_next    = TX_WAIT_POS_EDGE_BEFORE_ACK;
        end else if (clk_s) begin
          state_next = TX_CLK_HIGH;
        end
      end
      TX_CLK_HIGH: begin
        data_low_next = !tx_bit;    // device samples on this high phase
        if (!clk_s) state_next = TX_CLK_LOW;
      end

      // acknowledge
      TX_WAIT_POS_EDGE_BEFORE_ACK: begin
        if (clk_s) state_next = TX_WAIT_ACK;
      end
      TX_WAIT_ACK: begin
        if (!clk_s) begin
          state_next = data_s ? TX_ERROR_NO_ACK : TX_RECEIVED_ACK;  // ack is data low
        end
      end
      TX_RECEIVED_ACK: begin
        if (clk_s && data_s) state_next = IDLE;  // bus idle again
      end
      TX_ERROR_NO_ACK: begin
        if (clk_s && data_s) begin
          err_next   = 1'b1;        // lands with busy falling
          state_next = IDLE;
        end
      end

      default: state_next = IDLE;
    endcase
  end

endmodule

// ==== rtl/ps2_host.sv ====
`timescale 1ns/1ps

module ps2_host (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ps2_clk_in,    // clock line as seen on the bus
  input  logic                                ps2_data_in,   // data line as seen on the bus
  output logic                                ps2_clk_low,   // pull clock low
  output logic                                ps2_data_low,  // pull data low
  input  logic [ps2_frame_pkg::DATA_BITS-1:0] tx_data,
  input  logic                                tx_valid,
  output logic [ps2_frame_pkg::DATA_BITS-1:0] rx_data,
  output logic                                rx_valid,
  output logic                                busy,
  output logic                                err
);

  logic clk_s, data_s;              // filtered lines
  logic timer_clear, timer_run;
  logic hold_done, setup_done, release_done;
  logic frame_load, frame_shift, count_clear, rx_capture;
  logic tx_bit, frame_full, tx_last, parity_ok;

  ////////////////////////////////////////
  // line filters
  ////////////////////////////////////////

  ps2_line_filter u_clk_filter (
    .clk     (clk),
    .rst     (rst),
    .line_in (ps2_clk_in),
    .line_s  (clk_s)
  );

  ps2_line_filter u_data_filter (
    .clk     (clk),
    .rst     (rst),
    .line_in (ps2_data_in),
    .line_s  (data_s)
  );

  ////////////////////////////////////////
  // timer, shifter, control
  ////////////////////////////////////////

  ps2_delay_timer u_timer (
    .clk          (clk),
    .rst          (rst),
    .timer_clear  (timer_clear),
    .timer_run    (timer_run),
    .hold_done    (hold_done),
    .setup_done   (setup_done),
    .release_done (release_done)
  );

  ps2_frame_shifter u_shifter (
    .clk         (clk),
    .rst         (rst),
    .tx_data     (tx_data),
    .frame_load  (frame_load),
    .frame_shift (frame_shift),
    .count_clear (count_clear),
    .rx_capture  (rx_capture),
    .data_s      (data_s),
    .tx_bit      (tx_bit),
    .frame_full  (frame_full),
    .tx_last     (tx_last),
    .parity_ok   (parity_ok),
    .rx_data     (rx_data)
  );

  ps2_link_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .tx_valid     (tx_valid),
    .clk_s        (clk_s),
    .data_s       (data_s),
    .hold_done    (hold_done),
    .setup_done   (setup_done),
    .release_done (release_done),
    .tx_bit       (tx_bit),
    .frame_full   (frame_full),
    .tx_last      (tx_last),
    .parity_ok    (parity_ok),
    .timer_clear  (timer_clear),
    .timer_run    (timer_run),
    .frame_load   (frame_load),
    .frame_shift  (frame_shift),
    .count_clear  (count_clear),
    .rx_capture   (rx_capture),
    .ps2_clk_low  (ps2_clk_low),
    .ps2_data_low (ps2_data_low),
    .rx_valid     (rx_valid),
    .busy         (busy),
    .err          (err)
  );

endmodule

// ==== sim/ps2_host_tb.sv ====
`timescale 1ns/1ps

module ps2_host_tb;

  import ps2_frame_pkg::*;
  import ps2_ctrl_pkg::*;

  localparam int HALF_CYCLES    = 200;                // device clock half period
  localparam int GAP_CYCLES     = 200;                // idle bus between frames
  localparam int FRAME_CYCLES   = 6000;               // one frame, request to send included
  localparam int TIMEOUT_CYCLES = 25 * FRAME_CYCLES;  // 14 frames run, room for 25

  logic                  clk;
  logic                  rst;
  logic                  ps2_clk_in;
  logic                  ps2_data_in;
  logic                  ps2_clk_low;
  logic                  ps2_data_low;
  logic [DATA_BITS-1:0]  tx_data;
  logic                  tx_valid;
  logic [DATA_BITS-1:0]  rx_data;
  logic                  rx_valid;
  logic                  busy;
  logic                  err;

  logic                  dev_clk;                     // device side, 0 pulls low
  logic                  dev_data;
  wire                   clk_bus  = dev_clk & ~ps2_clk_low;    // wired-and
  wire                   data_bus = dev_data & ~ps2_data_low;

  logic [7:0]            lfsr;
  logic [DATA_BITS-1:0]  exp_byte;                    // last good byte from the device
  logic [DATA_BITS-1:0]  tx_byte;                     // byte under transmit
  logic [FRAME_BITS-1:0] got_frame;                   // frame the device clocked in
  logic                  clk_low_q;
  int                    frames_done;
  int                    frames_checked;
  int                    rx_count;
  int                    err_count;
  int                    req_count;
  int                    cycles;

  ps2_host dut (
    .clk          (clk),
    .rst          (rst),
    .ps2_clk_in   (ps2_clk_in),
    .ps2_data_in  (ps2_data_in),
    .ps2_clk_low  (ps2_clk_low),
    .ps2_data_low (ps2_data_low),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .busy         (busy),
    .err          (err)
  );

  ////////////////////////////////////////
  // clock, bus, timeout
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                           // 10 MHz
  end

  // bus levels reach the DUT on the falling edge
  initial begin
    ps2_clk_in  = 1'b1;
    ps2_data_in = 1'b1;
    forever begin
      @(negedge clk);
      ps2_clk_in  <= clk_bus;
      ps2_data_in <= data_bus;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      fail_stop($sformatf("timeout after %0d cycles, DUT never finished", cycles));
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH t=%0t %s got=%0h expected=%0h", $time, name, got, exp));
    end
  endtask

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_byte(output logic [DATA_BITS-1:0] b);
    for (int i = 0; i < DATA_BITS; i++) begin
      lfsr = lfsr_step(lfsr);                         // one step per bit
      b[i] = lfsr[0];
    end
  endtask

  // start 0, data lsb first, odd parity, stop 1
  function automatic logic [FRAME_BITS-1:0] ref_frame(input logic [DATA_BITS-1:0] b);
    int   ones;
    logic par;
    ones = 0;
    for (int i = 0; i < DATA_BITS; i++) begin
      if (b[i]) ones++;
    end
    par = (ones % 2 == 0);                            // even count needs a 1 to turn odd
    return {1'b1, par, b, 1'b0};
  endfunction

  // device to host with data set up mid high phase
  task automatic send_device_frame(input logic [FRAME_BITS-1:0] frame);
    for (int i = 0; i < FRAME_BITS; i++) begin
      dev_data <= frame[i];
      repeat (HALF_CYCLES/2) @(negedge clk);
      dev_clk <= 1'b0;                                // host samples on this edge
      repeat (HALF_CYCLES) @(negedge clk);
      dev_clk <= 1'b1;
      if (i < FRAME_BITS-1) repeat (HALF_CYCLES/2) @(negedge clk);
    end
    dev_data <= 1'b1;
  endtask

  // host to device from request to send through the ack clock
  task automatic capture_host_frame(input logic ack);
    logic [FRAME_BITS-1:0] cap;
    int                    hold;
    int                    setup;
    hold  = 0;
    setup = 0;
    while (!ps2_clk_low) @(negedge clk);
    while (!ps2_data_low) begin                       // clock alone held low
      hold++;
      @(negedge clk);
    end
    while (ps2_clk_low) begin                         // both lines low
      setup++;
      @(negedge clk);
    end
    check("clk hold cycles", hold, CLK_HOLD_CYCLES + 1);
    check("data setup cycles", setup, DATA_SETUP_CYCLES + 1);
    cap[0] = data_bus;                                // start bit from the request
    repeat (HALF_CYCLES/2) @(negedge clk);
    for (int i = 1; i < FRAME_BITS; i++) begin
      dev_clk <= 1'b0;
      repeat (HALF_CYCLES) @(negedge clk);
      cap[i]  = data_bus;                             // read at the rising edge
      dev_clk <= 1'b1;
      repeat (HALF_CYCLES/2) @(negedge clk);
      if (i < FRAME_BITS-1) repeat (HALF_CYCLES/2) @(negedge clk);
    end
    dev_data <= !ack;                                 // ack is data low
    repeat (HALF_CYCLES/2) @(negedge clk);
    dev_clk <= 1'b0;
    repeat (HALF_CYCLES) @(negedge clk);
    dev_clk     <= 1'b1;
    dev_data    <= 1'b1;
    got_frame   <= cap;
    frames_done <= frames_done + 1;
  endtask

  task automatic pulse_tx(input logic [DATA_BITS-1:0] b);
    tx_data  = b;
    tx_valid = 1'b1;
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  task automatic wait_busy_low();
    while (busy) @(negedge clk);
  endtask

  task automatic settle();
    repeat (GAP_CYCLES) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      rx_count       <= 0;
      err_count      <= 0;
      req_count      <= 0;
      frames_checked <= 0;
      clk_low_q      <= 1'b0;
    end else begin
      clk_low_q <= ps2_clk_low;
      if (rx_valid) begin
        rx_count <= rx_count + 1;
        check("rx_data", 32'(rx_data), 32'(exp_byte));
      end
      if (err) err_count <= err_count + 1;
      if (ps2_clk_low && !clk_low_q) req_count <= req_count + 1;  // one per request
      if (frames_checked != frames_done) begin
        check("tx_frame", 32'(got_frame), 32'(ref_frame(tx_byte)));
        frames_checked <= frames_checked + 1;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    logic [DATA_BITS-1:0]  b;
    logic [FRAME_BITS-1:0] bad;
    int                    exp_rx;
    int                    exp_err;
    int                    exp_req;
    rst         = 1'b1;
    tx_valid    = 1'b0;
    tx_data     = '0;
    dev_clk     <= 1'b1;                              // bus idle high
    dev_data    <= 1'b1;
    frames_done <= 0;
    lfsr        = 8'd81;
    exp_byte    = '0;
    tx_byte     = '0;
    exp_rx      = 0;
    exp_err     = 0;
    exp_req     = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("busy", 32'(busy), 0);
    check("rx_valid", 32'(rx_valid), 0);
    check("err", 32'(err), 0);
    check("ps2_clk_low", 32'(ps2_clk_low), 0);
    check("ps2_data_low", 32'(ps2_data_low), 0);

    // device frames with good parity
    repeat (8) begin
      rand_byte(b);
      exp_byte = b;
      exp_rx++;
      send_device_frame(ref_frame(b));
      wait_busy_low();
      check("rx_valid at busy fall", 32'(rx_valid), 1);
      settle();
      check("rx_valid pulses", rx_count, exp_rx);
      check("err pulses", err_count, exp_err);
    end

    // parity flipped so the byte is dropped
    bad = ref_frame(~exp_byte);
    bad[DATA_BITS+1] = ~bad[DATA_BITS+1];
    exp_err++;
    send_device_frame(bad);
    wait_busy_low();
    check("err at busy fall", 32'(err), 1);
    settle();
    check("rx_valid pulses", rx_count, exp_rx);
    check("err pulses", err_count, exp_err);
    check("rx_data kept", 32'(rx_data), 32'(exp_byte));

    // four acked transmits and then one with no ack
    for (int n = 0; n < 5; n++) begin
      rand_byte(b);
      tx_byte = b;
      exp_req++;
      if (n == 4) exp_err++;
      check("busy before tx", 32'(busy), 0);
      pulse_tx(b);
      fork
        capture_host_frame(n != 4);
        if (n == 0) begin                             // stray request mid transfer
          repeat (300) @(negedge clk);
          check("busy at stray tx_valid", 32'(busy), 1);
          pulse_tx(~b);
        end
      join
      wait_busy_low();
      check("err at busy fall", 32'(err), 32'(n == 4));
      settle();
      check("tx requests", req_count, exp_req);
      check("err pulses", err_count, exp_err);
      check("tx frames compared", frames_checked, n + 1);
    end

    settle();
    if (rx_count == exp_rx && err_count == exp_err && req_count == exp_req) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_stop("pulse counts at the end of the run do not match the stimulus");
    end
  end

endmodule

// ==== all.f ====
rtl/ps2_frame_pkg.sv
rtl/ps2_ctrl_pkg.sv
rtl/ps2_line_filter.sv
rtl/ps2_delay_timer.sv
rtl/ps2_frame_shifter.sv
rtl/ps2_link_fsm.sv
rtl/ps2_host.sv
sim/ps2_host_tb.sv

// ==== Makefile ====
TOP = ps2_host_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -F '>>> PASS' > /dev/null

clean:
	rm -rf obj_dir
